// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	////////////////////////////////////////////////////////////
	// Widths and reset state
	////////////////////////////////////////////////////////////
	localparam int XLEN = 32;
	localparam int REG_AW = 5;
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// MIPS32 primary opcodes
	localparam logic [5:0] OPC_SPECIAL = 6'h00;
	localparam logic [5:0] OPC_J = 6'h02;
	localparam logic [5:0] OPC_BEQ = 6'h04;
	localparam logic [5:0] OPC_BNE = 6'h05;
	localparam logic [5:0] OPC_ADDIU = 6'h09;
	localparam logic [5:0] OPC_ORI = 6'h0d;
	localparam logic [5:0] OPC_LUI = 6'h0f;
	localparam logic [5:0] OPC_LW = 6'h23;
	localparam logic [5:0] OPC_SW = 6'h2b;

	// Function field of SPECIAL
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	////////////////////////////////////////////////////////////
	// Decoded instruction and control encodings
	////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_SLT,
		OP_ADDIU, OP_ORI, OP_LUI, OP_LW, OP_SW,
		OP_BEQ, OP_BNE, OP_J, OP_NOP
	} op_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI
	} alu_op_e;

	// Source of a decode operand, youngest producer wins
	typedef enum logic [1:0] {
		FWD_REG, FWD_EX, FWD_MEM, FWD_WB
	} fwd_sel_e;

	////////////////////////////////////////////////////////////
	// Pipeline registers
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic regwr;
		logic memtoreg;
		logic memwr;
		logic alu_b_imm;
		alu_op_e alu_op;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] imm_ext;
		logic [REG_AW-1:0] dst;
	} idex_t;

	typedef struct packed {
		logic regwr;
		logic memtoreg;
		logic memwr;
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] wdata;
		logic [REG_AW-1:0] dst;
	} exmem_t;

	// Writeback bus into the register file
	typedef struct packed {
		logic regwr;
		logic [XLEN-1:0] data;
		logic [REG_AW-1:0] dst;
	} wb_t;

endpackage

`default_nettype wire

// ==== rtl/gpr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpr_file (
	input logic clk_i,
	input logic rst_n_i,
	input logic [cpu_pkg::REG_AW-1:0] rs_addr_i,
	input logic [cpu_pkg::REG_AW-1:0] rt_addr_i,
	input cpu_pkg::wb_t wb_i,
	output logic [cpu_pkg::XLEN-1:0] rs_data_o,
	output logic [cpu_pkg::XLEN-1:0] rt_data_o
);

	// No storage behind r0
	logic [cpu_pkg::XLEN-1:0] regs [1:31];

	function automatic logic [cpu_pkg::XLEN-1:0] read_port(
		input logic [cpu_pkg::REG_AW-1:0] addr
	);
		if (addr == '0) begin
			return '0;
		end
		// Same-cycle write is seen by the reader
		if (wb_i.regwr && wb_i.dst == addr) begin
			return wb_i.data;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk_i) begin
		if (wb_i.regwr && wb_i.dst != '0) begin
			regs[wb_i.dst] <= wb_i.data;
		end
	end

	always_comb begin
		rs_data_o = read_port(rs_addr_i);
		rt_data_o = read_port(rt_addr_i);
	end

	// A written register reads back its value on the next cycle
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(wb_i.regwr && wb_i.dst != '0) |=>
		(rs_addr_i != $past(wb_i.dst) || wb_i.regwr || rs_data_o == $past(wb_i.data)))
		else $error("register read back differs from the last write");

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input logic clk_i,
	input logic rst_n_i,
	input logic pause_i,
	input logic stall_i,
	input logic flush_i,
	input logic redirect_i,
	input logic [cpu_pkg::XLEN-1:0] target_i,
	input logic [cpu_pkg::XLEN-1:0] instr_i,
	output logic [cpu_pkg::XLEN-1:0] pc_o,
	output logic [cpu_pkg::XLEN-1:0] id_pc_o,
	output logic [cpu_pkg::XLEN-1:0] id_instr_o
);

	logic [cpu_pkg::XLEN-1:0] pc_q;
	logic [cpu_pkg::XLEN-1:0] pc_next;
	logic hold;

	assign hold = pause_i | stall_i;
	assign pc_next = redirect_i ? target_i : pc_q + 32'd4;
	assign pc_o = pc_q;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q <= cpu_pkg::RESET_PC;
		end else if (!hold) begin
			pc_q <= pc_next;
		end
	end

	// IF/ID, a flushed slot becomes the all-zero word which decodes as a NOP
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			id_pc_o <= cpu_pkg::RESET_PC;
			id_instr_o <= '0;
		end else if (!hold) begin
			id_pc_o <= pc_q;
			id_instr_o <= flush_i ? '0 : instr_i;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input logic [cpu_pkg::REG_AW-1:0] id_rs_i,
	input logic [cpu_pkg::REG_AW-1:0] id_rt_i,
	input logic id_uses_rt_i,
	input logic id_branch_i,
	input logic redirect_i,
	input logic [cpu_pkg::REG_AW-1:0] ex_dst_i,
	input logic ex_regwr_i,
	input logic ex_load_i,
	input logic [cpu_pkg::REG_AW-1:0] mem_dst_i,
	input logic mem_regwr_i,
	input cpu_pkg::wb_t wb_i,
	output cpu_pkg::fwd_sel_e fwd_a_o,
	output cpu_pkg::fwd_sel_e fwd_b_o,
	output logic stall_o,
	output logic flush_o
);

	logic ex_hit;

	function automatic cpu_pkg::fwd_sel_e pick_src(
		input logic [cpu_pkg::REG_AW-1:0] src,
		input logic ex_wr,
		input logic [cpu_pkg::REG_AW-1:0] ex_dst,
		input logic mem_wr,
		input logic [cpu_pkg::REG_AW-1:0] mem_dst,
		input cpu_pkg::wb_t wb
	);
		// r0 never forwards
		return (src == '0) ? cpu_pkg::FWD_REG :
			(ex_wr && ex_dst == src) ? cpu_pkg::FWD_EX :
			(mem_wr && mem_dst == src) ? cpu_pkg::FWD_MEM :
			(wb.regwr && wb.dst == src) ? cpu_pkg::FWD_WB :
			cpu_pkg::FWD_REG;
	endfunction

	assign fwd_a_o = pick_src(id_rs_i, ex_regwr_i, ex_dst_i, mem_regwr_i, mem_dst_i, wb_i);
	assign fwd_b_o = pick_src(id_rt_i, ex_regwr_i, ex_dst_i, mem_regwr_i, mem_dst_i, wb_i);

	// EX writes a register that decode reads this cycle
	assign ex_hit = ex_regwr_i && ex_dst_i != '0 &&
		(ex_dst_i == id_rs_i || (id_uses_rt_i && ex_dst_i == id_rt_i));

	// Load data is not ready in EX, and the compare path is too long for EX results
	assign stall_o = ex_hit && (ex_load_i || id_branch_i);
	assign flush_o = redirect_i && !stall_o;

	// Load-use detection only sees loads that write a register
	always_comb begin
		assert (!ex_load_i || ex_regwr_i)
			else $error("load in EX without register write");
	end

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input logic clk_i,
	input logic rst_n_i,
	input logic pause_i,
	input logic stall_i,
	input logic [cpu_pkg::XLEN-1:0] pc_i,
	input logic [cpu_pkg::XLEN-1:0] instr_i,
	input cpu_pkg::fwd_sel_e fwd_a_i,
	input cpu_pkg::fwd_sel_e fwd_b_i,
	input logic [cpu_pkg::XLEN-1:0] ex_result_i,
	input logic [cpu_pkg::XLEN-1:0] mem_data_i,
	input cpu_pkg::wb_t wb_i,
	output logic [cpu_pkg::REG_AW-1:0] rs_addr_o,
	output logic [cpu_pkg::REG_AW-1:0] rt_addr_o,
	output logic uses_rt_o,
	output logic branch_o,
	output logic redirect_o,
	output logic [cpu_pkg::XLEN-1:0] target_o,
	output cpu_pkg::idex_t idex_o
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [15:0] imm;
	logic [cpu_pkg::REG_AW-1:0] rd;
	logic [cpu_pkg::XLEN-1:0] rs_val;
	logic [cpu_pkg::XLEN-1:0] rt_val;
	logic [cpu_pkg::XLEN-1:0] op_a;
	logic [cpu_pkg::XLEN-1:0] op_b;
	logic [cpu_pkg::XLEN-1:0] pc_plus4;
	logic is_rtype;
	logic eq;
	cpu_pkg::op_e op;
	cpu_pkg::idex_t idex_d;

	assign opcode = instr_i[31:26];
	assign funct = instr_i[5:0];
	assign imm = instr_i[15:0];
	assign rd = instr_i[15:11];
	assign rs_addr_o = instr_i[25:21];
	assign rt_addr_o = instr_i[20:16];

	gpr_file u_gpr_file (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.rs_addr_i(rs_addr_o),
		.rt_addr_i(rt_addr_o),
		.wb_i(wb_i),
		.rs_data_o(rs_val),
		.rt_data_o(rt_val)
	);

	////////////////////////////////////////////////////////////
	// Instruction decode
	////////////////////////////////////////////////////////////
	always_comb begin
		op = cpu_pkg::OP_NOP;
		case (opcode)
			cpu_pkg::OPC_SPECIAL: begin
				case (funct)
					cpu_pkg::FN_ADDU: op = cpu_pkg::OP_ADDU;
					cpu_pkg::FN_SUBU: op = cpu_pkg::OP_SUBU;
					cpu_pkg::FN_AND: op = cpu_pkg::OP_AND;
					cpu_pkg::FN_OR: op = cpu_pkg::OP_OR;
					cpu_pkg::FN_SLT: op = cpu_pkg::OP_SLT;
					default: op = cpu_pkg::OP_NOP;
				endcase
			end
			cpu_pkg::OPC_ADDIU: op = cpu_pkg::OP_ADDIU;
			cpu_pkg::OPC_ORI: op = cpu_pkg::OP_ORI;
			cpu_pkg::OPC_LUI: op = cpu_pkg::OP_LUI;
			cpu_pkg::OPC_LW: op = cpu_pkg::OP_LW;
			cpu_pkg::OPC_SW: op = cpu_pkg::OP_SW;
			cpu_pkg::OPC_BEQ: op = cpu_pkg::OP_BEQ;
			cpu_pkg::OPC_BNE: op = cpu_pkg::OP_BNE;
			cpu_pkg::OPC_J: op = cpu_pkg::OP_J;
			default: op = cpu_pkg::OP_NOP;
		endcase
	end

	assign is_rtype = op inside {cpu_pkg::OP_ADDU, cpu_pkg::OP_SUBU, cpu_pkg::OP_AND,
		cpu_pkg::OP_OR, cpu_pkg::OP_SLT};
	assign uses_rt_o = is_rtype || op inside {cpu_pkg::OP_SW, cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE};
	assign branch_o = op inside {cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE};

	// Operand select, mirrors the four-input selectors of the EX forwarding path
	function automatic logic [cpu_pkg::XLEN-1:0] fwd_mux(
		input cpu_pkg::fwd_sel_e sel,
		input logic [cpu_pkg::XLEN-1:0] reg_val,
		input logic [cpu_pkg::XLEN-1:0] ex_val,
		input logic [cpu_pkg::XLEN-1:0] mem_val,
		input logic [cpu_pkg::XLEN-1:0] wb_val
	);
		case (sel)
			cpu_pkg::FWD_EX: return ex_val;
			cpu_pkg::FWD_MEM: return mem_val;
			cpu_pkg::FWD_WB: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign op_a = fwd_mux(fwd_a_i, rs_val, ex_result_i, mem_data_i, wb_i.data);
	assign op_b = fwd_mux(fwd_b_i, rt_val, ex_result_i, mem_data_i, wb_i.data);

	// Branch resolution, no delay slot
	assign eq = op_a == op_b;
	assign pc_plus4 = pc_i + 32'd4;
	assign redirect_o = (op == cpu_pkg::OP_J) || (op == cpu_pkg::OP_BEQ && eq) ||
		(op == cpu_pkg::OP_BNE && !eq);
	assign target_o = (op == cpu_pkg::OP_J) ? {pc_plus4[31:28], instr_i[25:0], 2'b00} :
		pc_plus4 + {{14{imm[15]}}, imm, 2'b00};

	always_comb begin
		idex_d = '0;
		idex_d.regwr = is_rtype || op inside {cpu_pkg::OP_ADDIU, cpu_pkg::OP_ORI,
			cpu_pkg::OP_LUI, cpu_pkg::OP_LW};
		idex_d.memtoreg = op == cpu_pkg::OP_LW;
		idex_d.memwr = op == cpu_pkg::OP_SW;
		idex_d.alu_b_imm = op inside {cpu_pkg::OP_ADDIU, cpu_pkg::OP_ORI, cpu_pkg::OP_LUI,
			cpu_pkg::OP_LW, cpu_pkg::OP_SW};
		case (op)
			cpu_pkg::OP_SUBU: idex_d.alu_op = cpu_pkg::ALU_SUB;
			cpu_pkg::OP_AND: idex_d.alu_op = cpu_pkg::ALU_AND;
			cpu_pkg::OP_OR, cpu_pkg::OP_ORI: idex_d.alu_op = cpu_pkg::ALU_OR;
			cpu_pkg::OP_SLT: idex_d.alu_op = cpu_pkg::ALU_SLT;
			cpu_pkg::OP_LUI: idex_d.alu_op = cpu_pkg::ALU_LUI;
			default: idex_d.alu_op = cpu_pkg::ALU_ADD;
		endcase
		idex_d.a = op_a;
		idex_d.b = op_b;
		// ORI zero-extends, the rest sign-extend
		idex_d.imm_ext = (op == cpu_pkg::OP_ORI) ? {16'h0000, imm} : {{16{imm[15]}}, imm};
		idex_d.dst = is_rtype ? rd : rt_addr_o;
	end

	// ID/EX, stall inserts a bubble
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			idex_o <= '0;
		end else if (!pause_i) begin
			idex_o <= stall_i ? '0 : idex_d;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/exec_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_mem_stage (
	input logic clk_i,
	input logic rst_n_i,
	input logic pause_i,
	input cpu_pkg::idex_t idex_i,
	input logic [cpu_pkg::XLEN-1:0] dm_dat_i,
	output logic [cpu_pkg::XLEN-1:0] ex_result_o,
	output logic [cpu_pkg::REG_AW-1:0] ex_dst_o,
	output logic ex_regwr_o,
	output logic ex_load_o,
	output logic [cpu_pkg::REG_AW-1:0] mem_dst_o,
	output logic mem_regwr_o,
	output logic [cpu_pkg::XLEN-1:0] mem_data_o,
	output cpu_pkg::wb_t wb_o,
	output logic [cpu_pkg::XLEN-1:0] dm_adr_o,
	output logic [cpu_pkg::XLEN-1:0] dm_dat_o,
	output logic dm_en_o,
	output logic dm_wr_o
);

	logic [cpu_pkg::XLEN-1:0] alu_b;
	cpu_pkg::exmem_t exmem_q;

	////////////////////////////////////////////////////////////
	// EX
	////////////////////////////////////////////////////////////
	assign alu_b = idex_i.alu_b_imm ? idex_i.imm_ext : idex_i.b;

	always_comb begin
		case (idex_i.alu_op)
			cpu_pkg::ALU_SUB: ex_result_o = idex_i.a - alu_b;
			cpu_pkg::ALU_AND: ex_result_o = idex_i.a & alu_b;
			cpu_pkg::ALU_OR: ex_result_o = idex_i.a | alu_b;
			cpu_pkg::ALU_SLT: ex_result_o = {31'd0, $signed(idex_i.a) < $signed(alu_b)};
			cpu_pkg::ALU_LUI: ex_result_o = {alu_b[15:0], 16'h0000};
			default: ex_result_o = idex_i.a + alu_b;
		endcase
	end

	assign ex_dst_o = idex_i.dst;
	assign ex_regwr_o = idex_i.regwr;
	assign ex_load_o = idex_i.memtoreg;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			exmem_q <= '0;
		end else if (!pause_i) begin
			exmem_q.regwr <= idex_i.regwr;
			exmem_q.memtoreg <= idex_i.memtoreg;
			exmem_q.memwr <= idex_i.memwr;
			exmem_q.result <= ex_result_o;
			exmem_q.wdata <= idex_i.b;
			exmem_q.dst <= idex_i.dst;
		end
	end

	////////////////////////////////////////////////////////////
	// MEM
	////////////////////////////////////////////////////////////
	assign dm_adr_o = exmem_q.result;
	assign dm_dat_o = exmem_q.wdata;
	assign dm_en_o = exmem_q.memtoreg | exmem_q.memwr;
	assign dm_wr_o = exmem_q.memwr;

	assign mem_dst_o = exmem_q.dst;
	assign mem_regwr_o = exmem_q.regwr;
	assign mem_data_o = exmem_q.memtoreg ? dm_dat_i : exmem_q.result;

	// MEM/WB
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_o <= '0;
		end else if (!pause_i) begin
			wb_o.regwr <= exmem_q.regwr;
			wb_o.data <= mem_data_o;
			wb_o.dst <= exmem_q.dst;
		end
	end

	// Loads and stores form their address as base plus offset
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(idex_i.memtoreg || idex_i.memwr) |->
		(idex_i.alu_b_imm && idex_i.alu_op == cpu_pkg::ALU_ADD))
		else $error("memory access without base plus offset address");

endmodule

`default_nettype wire

// ==== rtl/pipeline_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_cpu (
	input logic clk_i,
	input logic rst_n_i,
	input logic ext_pause_i,
	output logic [cpu_pkg::XLEN-1:0] im_adr_o,
	input logic [cpu_pkg::XLEN-1:0] im_dat_i,
	output logic [cpu_pkg::XLEN-1:0] dm_adr_o,
	output logic [cpu_pkg::XLEN-1:0] dm_dat_o,
	output logic dm_en_o,
	output logic dm_wr_o,
	input logic [cpu_pkg::XLEN-1:0] dm_dat_i
);

	////////////////////////////////////////////////////////////
	// Inter-stage wires
	////////////////////////////////////////////////////////////
	logic [cpu_pkg::XLEN-1:0] id_pc;
	logic [cpu_pkg::XLEN-1:0] id_instr;
	logic [cpu_pkg::XLEN-1:0] id_target;
	logic [cpu_pkg::REG_AW-1:0] id_rs_addr;
	logic [cpu_pkg::REG_AW-1:0] id_rt_addr;
	logic id_uses_rt;
	logic id_branch;
	logic id_redirect;
	cpu_pkg::fwd_sel_e id_fwd_a;
	cpu_pkg::fwd_sel_e id_fwd_b;
	cpu_pkg::idex_t idex;
	logic [cpu_pkg::XLEN-1:0] ex_result;
	logic [cpu_pkg::REG_AW-1:0] ex_dst;
	logic ex_regwr;
	logic ex_load;
	logic [cpu_pkg::REG_AW-1:0] mem_dst;
	logic mem_regwr;
	logic [cpu_pkg::XLEN-1:0] mem_data;
	cpu_pkg::wb_t wb;
	logic stall_id;
	logic flush_if;

	fetch_stage u_fetch_stage (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.pause_i(ext_pause_i),
		.stall_i(stall_id),
		.flush_i(flush_if),
		.redirect_i(id_redirect),
		.target_i(id_target),
		.instr_i(im_dat_i),
		.pc_o(im_adr_o),
		.id_pc_o(id_pc),
		.id_instr_o(id_instr)
	);

	decode_stage u_decode_stage (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.pause_i(ext_pause_i),
		.stall_i(stall_id),
		.pc_i(id_pc),
		.instr_i(id_instr),
		.fwd_a_i(id_fwd_a),
		.fwd_b_i(id_fwd_b),
		.ex_result_i(ex_result),
		.mem_data_i(mem_data),
		.wb_i(wb),
		.rs_addr_o(id_rs_addr),
		.rt_addr_o(id_rt_addr),
		.uses_rt_o(id_uses_rt),
		.branch_o(id_branch),
		.redirect_o(id_redirect),
		.target_o(id_target),
		.idex_o(idex)
	);

	hazard_unit u_hazard_unit (
		.id_rs_i(id_rs_addr),
		.id_rt_i(id_rt_addr),
		.id_uses_rt_i(id_uses_rt),
		.id_branch_i(id_branch),
		.redirect_i(id_redirect),
		.ex_dst_i(ex_dst),
		.ex_regwr_i(ex_regwr),
		.ex_load_i(ex_load),
		.mem_dst_i(mem_dst),
		.mem_regwr_i(mem_regwr),
		.wb_i(wb),
		.fwd_a_o(id_fwd_a),
		.fwd_b_o(id_fwd_b),
		.stall_o(stall_id),
		.flush_o(flush_if)
	);

	exec_mem_stage u_exec_mem_stage (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.pause_i(ext_pause_i),
		.idex_i(idex),
		.dm_dat_i(dm_dat_i),
		.ex_result_o(ex_result),
		.ex_dst_o(ex_dst),
		.ex_regwr_o(ex_regwr),
		.ex_load_o(ex_load),
		.mem_dst_o(mem_dst),
		.mem_regwr_o(mem_regwr),
		.mem_data_o(mem_data),
		.wb_o(wb),
		.dm_adr_o(dm_adr_o),
		.dm_dat_o(dm_dat_o),
		.dm_en_o(dm_en_o),
		.dm_wr_o(dm_wr_o)
	);

endmodule

`default_nettype wire

// ==== test/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

////////////////////////////////////////////////////////////
// Test program, one MIPS32 word per address, no delay slots
////////////////////////////////////////////////////////////
localparam int PROG_LEN = 33;

localparam logic [31:0] PROG [PROG_LEN] = '{
	// ori r1 0x0f0c, lui r2 0x00f0, then addu subu and or slt back to back
	32'h34010F0C, 32'h3C0200F0, 32'h00221821, 32'h00432023,
	32'h00832824, 32'h00813025, 32'h0081382A,
	// sw r3..r7 to 0x80..0x90, addiu r8 r7 -3, sw r8 to 0x94
	32'hAC030080, 32'hAC040084, 32'hAC050088, 32'hAC06008C,
	32'hAC070090, 32'h24E8FFFD, 32'hAC080094,
	// lw r9 0x10, addu r10 r9 r1 right behind it, sw r10 to 0x98
	32'h8C090010, 32'h01215021, 32'hAC0A0098,
	// lw r11 0x84 feeding the store data of sw r11 to 0x9c
	32'h8C0B0084, 32'hAC0B009C,
	// beq r1 r3 falls through to sw r1 to 0xa0
	32'h10230001, 32'hAC0100A0,
	// addiu r12 5, bne r12 r0 taken over a poison store to 0xfc
	32'h240C0005, 32'h15800001, 32'hAC0200FC,
	// subu r13 r12 r7, beq r13 r12 not taken, sw r13 to 0xa4
	32'h01876823, 32'h11AC0001, 32'hAC0D00A4,
	// beq r12 r12 and j 31 each skip a poison store
	32'h118C0001, 32'hAC0200F8, 32'h0800001F, 32'hAC0200F4,
	// sw r12 to 0xa8, then spin on a self jump
	32'hAC0C00A8, 32'h08000020
};

////////////////////////////////////////////////////////////
// Stores in program order
////////////////////////////////////////////////////////////
localparam int STORE_COUNT = 11;

localparam logic [31:0] EXP_ADR [STORE_COUNT] = '{
	32'h80, 32'h84, 32'h88, 32'h8C, 32'h90, 32'h94,
	32'h98, 32'h9C, 32'hA0, 32'hA4, 32'hA8
};

localparam logic [31:0] EXP_DAT [STORE_COUNT] = '{
	32'h00F00F0C, 32'hFFFFF0F4, 32'h00F00004, 32'hFFFFFFFC,
	32'h00000001, 32'hFFFFFFFE, 32'h5A000F1C, 32'hFFFFF0F4,
	32'h00000F0C, 32'h00000004, 32'h00000005
};

function automatic string store_test_name(input logic [3:0] idx);
	case (idx)
		4'd0: return "alu_addu";
		4'd1: return "alu_subu";
		4'd2: return "alu_and";
		4'd3: return "alu_or";
		4'd4: return "alu_slt";
		4'd5: return "alu_addiu";
		4'd6: return "load_use";
		4'd7: return "load_store_data";
		4'd8: return "branch_not_taken";
		4'd9: return "branch_fresh_operand";
		4'd10: return "jump_over";
		default: return "unknown";
	endcase
endfunction

`endif

// ==== test/tb_pipeline_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_cpu;

	localparam int RESET_CYCLES = 4;
	localparam int PAUSE_BUDGET = 40;
	localparam int DRAIN_CYCLES = 10;

	`include "tb_programs.svh"

	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * PROG_LEN + PAUSE_BUDGET + 100;

	logic clk;
	logic rst_n;
	logic ext_pause;
	logic [31:0] im_adr;
	logic [31:0] im_dat;
	logic [31:0] dm_adr;
	logic [31:0] dm_dat_wr;
	logic [31:0] dm_dat_rd;
	logic dm_en;
	logic dm_wr;
	logic [31:0] dmem [64];
	logic [3:0] store_idx;
	int cycle = 0;
	int pause_left;
	int pause_used;

	pipeline_cpu u_pipeline_cpu (
		.clk_i(clk),
		.rst_n_i(rst_n),
		.ext_pause_i(ext_pause),
		.im_adr_o(im_adr),
		.im_dat_i(im_dat),
		.dm_adr_o(dm_adr),
		.dm_dat_o(dm_dat_wr),
		.dm_en_o(dm_en),
		.dm_wr_o(dm_wr),
		.dm_dat_i(dm_dat_rd)
	);

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Memory models
	////////////////////////////////////////////////////////////
	// Outside the program the ROM reads as NOP
	assign im_dat = ({2'b00, im_adr[31:2]} < PROG_LEN) ? PROG[im_adr[7:2]] : 32'h0;
	// Read data only for an enabled load
	assign dm_dat_rd = (dm_en && !dm_wr) ? dmem[dm_adr[7:2]] : 32'h0;

	// A paused store is written once, on the edge that releases it
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 64; i++) begin
				dmem[i[5:0]] <= 32'h5A00_0000 | {24'd0, i[5:0], 2'b00};
			end
		end else if (dm_wr && !ext_pause) begin
			dmem[dm_adr[7:2]] <= dm_dat_wr;
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (!rst_n) begin
			store_idx <= 4'd0;
		end else if (dm_wr && !ext_pause) begin
			store_idx <= store_idx + 4'd1;
		end
	end

	// Random pause bursts of one to four cycles
	initial begin
		void'($urandom(4));
		forever begin
			@(posedge clk);
			if (!rst_n) begin
				ext_pause <= 1'b0;
				pause_left <= 0;
				pause_used <= 0;
			end else if (pause_used >= PAUSE_BUDGET) begin
				ext_pause <= 1'b0;
			end else if (pause_left > 0) begin
				ext_pause <= 1'b1;
				pause_left <= pause_left - 1;
				pause_used <= pause_used + 1;
			end else if ($urandom_range(5, 0) == 0) begin
				ext_pause <= 1'b1;
				pause_left <= $urandom_range(3, 0);
				pause_used <= pause_used + 1;
			end else begin
				ext_pause <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks sampled on the falling edge
	////////////////////////////////////////////////////////////
	assert property (@(negedge clk) (cycle >= 1 && cycle <= RESET_CYCLES) |->
		(!dm_en && !dm_wr && im_adr == cpu_pkg::RESET_PC))
		else begin
			$display("Mismatch test=reset expected en=0 wr=0 pc=%08h actual en=%0b wr=%0b pc=%08h",
				cpu_pkg::RESET_PC, dm_en, dm_wr, im_adr);
			$display("Regression failed");
			$fatal(1);
		end

	assert property (@(negedge clk) disable iff (!rst_n)
		(dm_wr && !ext_pause) |-> (store_idx < 4'(STORE_COUNT)))
		else begin
			$display("Unexpected store to address %08h after the last expected store", dm_adr);
			$display("Regression failed");
			$fatal(1);
		end

	assert property (@(negedge clk) disable iff (!rst_n)
		(dm_wr && !ext_pause && store_idx < 4'(STORE_COUNT)) |->
		(dm_adr == EXP_ADR[store_idx]))
		else begin
			$display("Mismatch test=%s expected adr=%08h actual adr=%08h",
				store_test_name(store_idx), EXP_ADR[store_idx], dm_adr);
			$display("Regression failed");
			$fatal(1);
		end

	assert property (@(negedge clk) disable iff (!rst_n)
		(dm_wr && !ext_pause && store_idx < 4'(STORE_COUNT)) |->
		(dm_dat_wr == EXP_DAT[store_idx]))
		else begin
			$display("Mismatch test=%s expected dat=%08h actual dat=%08h",
				store_test_name(store_idx), EXP_DAT[store_idx], dm_dat_wr);
			$display("Regression failed");
			$fatal(1);
		end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		ext_pause = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		while (store_idx < 4'(STORE_COUNT) && cycle < TIMEOUT_CYCLES) begin
			@(posedge clk);
		end
		// Extra cycles so a stray store after the last one is still caught
		repeat (DRAIN_CYCLES) @(posedge clk);
		if (store_idx == 4'(STORE_COUNT)) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Timeout after %0d cycles with %0d of %0d stores seen",
				cycle, store_idx, STORE_COUNT);
			$display("Regression failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+test
rtl/cpu_pkg.sv
rtl/gpr_file.sv
rtl/fetch_stage.sv
rtl/hazard_unit.sv
rtl/decode_stage.sv
rtl/exec_mem_stage.sv
rtl/pipeline_cpu.sv
test/tb_pipeline_cpu.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_pipeline_cpu \
	-f filelist.f -o sim_pipeline_cpu > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_pipeline_cpu > sim.log 2>&1
grep -qx "Regression passed" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }
